/* include/mul_defines.svh */
`ifndef MUL_DEFINES_SVH
`define MUL_DEFINES_SVH

// operand and result word width
`define MUL_XLEN 32

// half word, one side of each partial product
// must stay MUL_XLEN / 2 for the split in the first stage
`define MUL_HALF 16

// register file index width, 32 architectural registers
`define MUL_REG_W 5

// full product is 2 * MUL_XLEN, formed from these where needed
// upper word picked for mulh / mulhu
// lower word for mul

`endif

/* rtl/mul_op_pkg.sv */
`include "mul_defines.svh"

package mul_op_pkg;

    // low two bits of funct3 for the multiply group
    // 2'b10 would be mulhsu, not supported, decodes as plain mul
    typedef enum logic [1:0] {
        MUL_OP_MUL   = 2'b00,
        MUL_OP_MULH  = 2'b01,
        MUL_OP_MULHU = 2'b11
    } mul_op_t;

    // one issued multiply as seen on the request port
    // op in the top bits, then destination, then operands
    typedef struct packed {
        // operation select
        mul_op_t                 op;
        // destination register index
        logic [`MUL_REG_W-1:0]   rd;
        // rs1 value
        logic [`MUL_XLEN-1:0]    src1;
        // rs2 value
        logic [`MUL_XLEN-1:0]    src2;
    } mul_req_t;

    // 2 + 5 + 32 + 32 = 71 bits

endpackage

/* rtl/mul_pipe_pkg.sv */
`include "mul_defines.svh"

package mul_pipe_pkg;

    // side information carried next to the data through the pipe
    // the multiplier itself never looks at it
    typedef struct packed {
        // destination register
        logic [`MUL_REG_W-1:0] rd;
        // take bits 63:32 at writeback
        logic                  sel_high;
    } mul_tag_t;

    // 5 + 1 = 6 bits

    // first stage output, registered inside the multiply pipe
    // all four products are unsigned half x half
    typedef struct packed {
        // src1 high x src2 high
        logic [`MUL_XLEN-1:0] hh;
        // src1 high x src2 low
        logic [`MUL_XLEN-1:0] hl;
        // src1 low x src2 high
        logic [`MUL_XLEN-1:0] lh;
        // src1 low x src2 low
        logic [`MUL_XLEN-1:0] ll;
        // signed correction, subtracted at bit MUL_XLEN
        // zero for unsigned operations
        logic [`MUL_XLEN-1:0] comp;
    } mul_partials_t;

    // 5 x 32 = 160 bits

    // the correction only matters modulo 2^MUL_XLEN
    // since it is shifted up by MUL_XLEN before the subtract
    // and the sum wraps at 2 * MUL_XLEN

endpackage

/* rtl/mul_partial_products.sv */
`timescale 1ns/1ps
`include "mul_defines.svh"

module mul_partial_products
    import mul_pipe_pkg::*;
(
    input  logic [`MUL_XLEN-1:0] src1,
    input  logic [`MUL_XLEN-1:0] src2,
    input  logic                 sign,
    output mul_partials_t        partials
);

    // operand halves
    logic [`MUL_HALF-1:0] a_hi;
    logic [`MUL_HALF-1:0] a_lo;
    logic [`MUL_HALF-1:0] b_hi;
    logic [`MUL_HALF-1:0] b_lo;

    // correction contributions from each operand's sign bit
    logic [`MUL_XLEN-1:0] comp_a;
    logic [`MUL_XLEN-1:0] comp_b;

    assign a_hi = src1[`MUL_XLEN-1:`MUL_HALF];
    assign a_lo = src1[`MUL_HALF-1:0];
    assign b_hi = src2[`MUL_HALF-1+`MUL_HALF:`MUL_HALF];
    assign b_lo = src2[`MUL_HALF-1:0];

    // unsigned half products, each fits in MUL_XLEN bits
    always_comb begin
        partials.hh = `MUL_XLEN'(a_hi) * `MUL_XLEN'(b_hi);
        partials.hl = `MUL_XLEN'(a_hi) * `MUL_XLEN'(b_lo);
        partials.lh = `MUL_XLEN'(a_lo) * `MUL_XLEN'(b_hi);
        partials.ll = `MUL_XLEN'(a_lo) * `MUL_XLEN'(b_lo);
        partials.comp = comp_a + comp_b;
    end

    // signed a = A - 2^32 * a31, same for b
    // a*b = A*B - 2^32 * (a31 * B + b31 * A) mod 2^64
    // so the correction is src2 when src1 is negative
    // plus src1 when src2 is negative
    always_comb begin
        comp_a = '0;
        comp_b = '0;
        if (sign) begin
            if (src1[`MUL_XLEN-1]) begin
                comp_a = src2;
            end
            if (src2[`MUL_XLEN-1]) begin
                comp_b = src1;
            end
        end
    end

    // the a31 * b31 * 2^64 term falls off the top
    // and needs no handling here

endmodule

/* rtl/mul_partial_sum.sv */
`timescale 1ns/1ps
`include "mul_defines.svh"

module mul_partial_sum
    import mul_pipe_pkg::*;
(
    input  mul_partials_t            partials,
    output logic [2*`MUL_XLEN-1:0]   product
);

    // partials placed at their weight in the full product
    logic [2*`MUL_XLEN-1:0] ll_w;
    logic [2*`MUL_XLEN-1:0] hl_w;
    logic [2*`MUL_XLEN-1:0] lh_w;
    logic [2*`MUL_XLEN-1:0] hh_w;
    logic [2*`MUL_XLEN-1:0] comp_w;

    // weight 1
    assign ll_w = {{`MUL_XLEN{1'b0}}, partials.ll};

    // weight 2^16, both cross terms
    assign hl_w = {{`MUL_HALF{1'b0}}, partials.hl, {`MUL_HALF{1'b0}}};
    assign lh_w = {{`MUL_HALF{1'b0}}, partials.lh, {`MUL_HALF{1'b0}}};

    // weight 2^32
    assign hh_w = {partials.hh, {`MUL_XLEN{1'b0}}};

    // signed correction also sits at 2^32
    assign comp_w = {partials.comp, {`MUL_XLEN{1'b0}}};

    // unsigned sum of the four products minus the correction
    // wraps at 64 bits, which is exactly what the signed case needs
    assign product = ll_w + hl_w + lh_w + hh_w - comp_w;

endmodule

/* rtl/mul_issue.sv */
`timescale 1ns/1ps
`include "mul_defines.svh"

module mul_issue
    import mul_op_pkg::*;
    import mul_pipe_pkg::*;
(
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 mul_en,
    input  mul_req_t             req,
    output logic                 issue_valid,
    output logic                 sign,
    output logic [`MUL_XLEN-1:0] src1,
    output logic [`MUL_XLEN-1:0] src2,
    output mul_tag_t             tag
);

    // decoded from req.op before the register
    logic dec_sign;
    logic dec_high;

    always_comb begin
        dec_sign = 1'b0;
        dec_high = 1'b0;
        case (req.op)
            MUL_OP_MULH: begin
                dec_sign = 1'b1;
                dec_high = 1'b1;
            end
            MUL_OP_MULHU: begin
                dec_high = 1'b1;
            end
            // mul and the unused mulhsu code
            default: begin
                dec_sign = 1'b0;
                dec_high = 1'b0;
            end
        endcase
    end

    // valid follows the strobe, one op per cycle at most
    always_ff @(posedge clk) begin
        if (!rstn) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= mul_en;
        end
    end

    // payload only moves on a real issue
    always_ff @(posedge clk) begin
        if (mul_en) begin
            sign         <= dec_sign;
            src1         <= req.src1;
            src2         <= req.src2;
            tag.rd       <= req.rd;
            tag.sel_high <= dec_high;
        end
    end

endmodule

/* rtl/mul_unit.sv */
`timescale 1ns/1ps
`include "mul_defines.svh"

module mul_unit
    import mul_pipe_pkg::*;
#(
    // carried alongside, never inspected
    parameter type tag_type = logic
)
(
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   in_valid,
    input  logic                   sign,
    input  logic [`MUL_XLEN-1:0]   src1,
    input  logic [`MUL_XLEN-1:0]   src2,
    input  tag_type                in_tag,
    output logic                   out_valid,
    output logic [2*`MUL_XLEN-1:0] product,
    output tag_type                out_tag
);

    // stage 1, combinational partials from the inputs
    mul_partials_t s1_partials_d;

    // stage 1 register
    logic          s1_valid;
    mul_partials_t s1_partials;
    tag_type       s1_tag;

    // stage 2, combinational sum of the registered partials
    logic [2*`MUL_XLEN-1:0] s2_sum;

    mul_partial_products u_partial_products (
        .src1     (src1),
        .sign     (sign),
        .src2     (src2),
        .partials (s1_partials_d)
    );

    // valid bits only, payload is don't care while invalid
    always_ff @(posedge clk) begin
        if (!rstn) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= in_valid;
            out_valid <= s1_valid;
        end
    end

    // partials register, edge 1 after the issue edge
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_partials <= s1_partials_d;
            s1_tag      <= in_tag;
        end
    end

    mul_partial_sum u_partial_sum (
        .partials (s1_partials),
        .product  (s2_sum)
    );

    // product register, edge 2
    // the tag moves with it so the writeback sees a matched pair
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            product <= s2_sum;
            out_tag <= s1_tag;
        end
    end

    // no stall, a new op can enter every cycle
    // two ops in here at most, one per register

endmodule

/* rtl/mul_writeback.sv */
`timescale 1ns/1ps
`include "mul_defines.svh"

module mul_writeback
    import mul_pipe_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   res_valid,
    input  logic [2*`MUL_XLEN-1:0] product,
    input  mul_tag_t               tag,
    output logic                   wb_en,
    output logic [`MUL_REG_W-1:0]  wb_rd,
    output logic [`MUL_XLEN-1:0]   wb_data
);

    // word picked from the product
    logic [`MUL_XLEN-1:0] res_word;

    // x0 is hardwired zero, never written
    logic                 rd_nonzero;

    // upper word for mulh / mulhu, lower for mul
    assign res_word = tag.sel_high ? product[2*`MUL_XLEN-1:`MUL_XLEN]
                                   : product[`MUL_XLEN-1:0];

    assign rd_nonzero = |tag.rd;

    // write strobe, one cycle per retired op
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= res_valid && rd_nonzero;
        end
    end

    // index and data held until the next valid result
    always_ff @(posedge clk) begin
        if (res_valid) begin
            wb_rd   <= tag.rd;
            wb_data <= res_word;
        end
    end

    // consumer has no way to push back
    // wb_en must be taken the cycle it is high

endmodule

/* rtl/mul_top.sv */
`timescale 1ns/1ps
`include "mul_defines.svh"

module mul_top
    import mul_op_pkg::*;
    import mul_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  mul_en,
    input  mul_req_t              req,
    output logic                  wb_en,
    output logic [`MUL_REG_W-1:0] wb_rd,
    output logic [`MUL_XLEN-1:0]  wb_data
);

    // issue to multiply pipe
    logic                   issue_valid;
    logic                   issue_sign;
    logic [`MUL_XLEN-1:0]   issue_src1;
    logic [`MUL_XLEN-1:0]   issue_src2;
    mul_tag_t               issue_tag;

    // multiply pipe to writeback
    logic                   res_valid;
    logic [2*`MUL_XLEN-1:0] res_product;
    mul_tag_t               res_tag;

    // edge 0, request capture and decode
    mul_issue u_issue (
        .clk         (clk),
        .rstn        (rstn),
        .mul_en      (mul_en),
        .req         (req),
        .issue_valid (issue_valid),
        .sign        (issue_sign),
        .src1        (issue_src1),
        .src2        (issue_src2),
        .tag         (issue_tag)
    );

    // edges 1 and 2, partials then product
    mul_unit #(
        .tag_type (mul_tag_t)
    ) u_unit (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (issue_valid),
        .sign      (issue_sign),
        .src1      (issue_src1),
        .src2      (issue_src2),
        .in_tag    (issue_tag),
        .out_valid (res_valid),
        .product   (res_product),
        .out_tag   (res_tag)
    );

    // edge 3, register file write
    mul_writeback u_writeback (
        .clk       (clk),
        .rstn      (rstn),
        .res_valid (res_valid),
        .product   (res_product),
        .tag       (res_tag),
        .wb_en     (wb_en),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

endmodule

/* verification/mul_tb.sv */
`timescale 1ns/1ps
`include "mul_defines.svh"

module mul_tb
    import mul_op_pkg::*;
;

    logic                  clk;
    logic                  rstn;
    logic                  mul_en;
    mul_req_t              req;
    logic                  wb_en;
    logic [`MUL_REG_W-1:0] wb_rd;
    logic [`MUL_XLEN-1:0]  wb_data;

    // rising edges seen so far
    int unsigned edge_cnt = 0;

    // expected writes in issue order
    logic [`MUL_REG_W-1:0] exp_rd_q[$];
    logic [`MUL_XLEN-1:0]  exp_data_q[$];
    int unsigned           exp_edge_q[$];

    // popped entry under check
    logic [`MUL_REG_W-1:0] got_rd;
    logic [`MUL_XLEN-1:0]  got_data;
    int unsigned           got_edge;

    logic [31:0] rng;
    int          i;
    int          j;

    // operands that stress the sign correction
    logic [`MUL_XLEN-1:0] corner_vals [0:4] = '{32'h0000_0000, 32'h0000_0001,
        32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};

    mul_top dut (
        .clk     (clk),
        .rstn    (rstn),
        .mul_en  (mul_en),
        .req     (req),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 32'd1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic mul_op_t pick_op(input logic [31:0] r);
        mul_op_t op;
        case (r % 32'd3)
            32'd0:   op = MUL_OP_MUL;
            32'd1:   op = MUL_OP_MULH;
            default: op = MUL_OP_MULHU;
        endcase
        return op;
    endfunction

    // reference word from the full 64-bit product
    function automatic logic [`MUL_XLEN-1:0] expected_word(input mul_op_t op,
            input logic [`MUL_XLEN-1:0] a, input logic [`MUL_XLEN-1:0] b);
        logic [2*`MUL_XLEN-1:0] sa;
        logic [2*`MUL_XLEN-1:0] sb;
        logic [2*`MUL_XLEN-1:0] ua;
        logic [2*`MUL_XLEN-1:0] ub;
        logic [2*`MUL_XLEN-1:0] sp;
        logic [2*`MUL_XLEN-1:0] up;
        logic [`MUL_XLEN-1:0]   w;
        sa = {{`MUL_XLEN{a[`MUL_XLEN-1]}}, a};
        sb = {{`MUL_XLEN{b[`MUL_XLEN-1]}}, b};
        ua = {{`MUL_XLEN{1'b0}}, a};
        ub = {{`MUL_XLEN{1'b0}}, b};
        // mod 2^64 product of sign extended values is the signed product
        sp = sa * sb;
        up = ua * ub;
        case (op)
            MUL_OP_MULH:  w = sp[2*`MUL_XLEN-1:`MUL_XLEN];
            MUL_OP_MULHU: w = up[2*`MUL_XLEN-1:`MUL_XLEN];
            // low word is the same for both signs
            default:      w = up[`MUL_XLEN-1:0];
        endcase
        return w;
    endfunction

    task automatic fail_value(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        $display("FAILED time=%0d ns signal=%s got=%h expected=%h", $time, name, got, exp);
        $display("TEST FAILED");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic fail_plain(input string msg);
        $display("%s at %0d ns", msg, $time);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    // inputs change 1 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic idle(input int n);
        repeat (n) tick();
    endtask

    task automatic issue_op(input mul_op_t op, input logic [`MUL_REG_W-1:0] rd,
            input logic [`MUL_XLEN-1:0] a, input logic [`MUL_XLEN-1:0] b);
        req.op   = op;
        req.rd   = rd;
        req.src1 = a;
        req.src2 = b;
        mul_en   = 1'b1;
        // x0 never shows up on the write port
        if (rd != '0) begin
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(expected_word(op, a, b));
            // sampled at the next edge
            exp_edge_q.push_back(edge_cnt + 32'd1);
        end
        tick();
        mul_en = 1'b0;
    endtask

    task automatic random_op(input logic force_rd, input logic [`MUL_REG_W-1:0] rd_val);
        logic [31:0]          sel;
        logic [`MUL_XLEN-1:0] a;
        logic [`MUL_XLEN-1:0] b;
        rng = xorshift32(rng);
        sel = rng;
        rng = xorshift32(rng);
        a = rng;
        rng = xorshift32(rng);
        b = rng;
        issue_op(pick_op(sel), force_rd ? rd_val : sel[31:27], a, b);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_rd_q.size() != 0 && waited < 200) begin
            tick();
            waited++;
        end
        if (exp_rd_q.size() != 0) begin
            fail_plain("timeout, results still pending after 200 cycles");
        end
        // a few quiet cycles to catch stray writes
        idle(4);
    endtask

    // scoreboard sampled on the falling edge away from input changes
    always @(negedge clk) begin
        if (wb_en === 1'b1) begin
            if (exp_rd_q.size() == 0) begin
                fail_plain("wb_en rose with no result expected");
            end else begin
                got_rd   = exp_rd_q.pop_front();
                got_data = exp_data_q.pop_front();
                got_edge = exp_edge_q.pop_front();
                assert (wb_rd == got_rd) else begin
                    fail_value("wb_rd", 32'(wb_rd), 32'(got_rd));
                end
                assert (wb_data == got_data) else begin
                    fail_value("wb_data", wb_data, got_data);
                end
                // writeback register loads on the third edge after issue
                assert (edge_cnt == got_edge + 32'd3) else begin
                    fail_value("wb_en edge", edge_cnt, got_edge + 32'd3);
                end
            end
        end
    end

    initial begin
        clk    = 1'b0;
        rstn   = 1'b0;
        mul_en = 1'b0;
        req    = '0;
        rng    = 32'h9ac5_2393;
        idle(4);
        rstn = 1'b1;
        idle(2);

        // random ops with random idle gaps
        for (i = 0; i < 2000; i++) begin
            random_op(1'b0, '0);
            rng = xorshift32(rng);
            idle(int'(rng[1:0]));
        end
        drain();

        // one op per cycle
        for (i = 0; i < 200; i++) begin
            random_op(1'b0, '0);
        end
        drain();

        // every corner pairing under all three ops
        for (i = 0; i < 5; i++) begin
            for (j = 0; j < 5; j++) begin
                issue_op(MUL_OP_MULH, 5'(i * 5 + j + 1), corner_vals[i], corner_vals[j]);
                issue_op(MUL_OP_MULHU, 5'(i * 5 + j + 1), corner_vals[i], corner_vals[j]);
                issue_op(MUL_OP_MUL, 5'(i * 5 + j + 1), corner_vals[i], corner_vals[j]);
            end
        end
        drain();

        // x0 writes interleaved with real ones
        for (i = 0; i < 100; i++) begin
            if (i % 2 == 0) begin
                random_op(1'b1, '0);
            end else begin
                random_op(1'b1, 5'(i % 31 + 1));
            end
        end
        drain();

        // reset with the pipe full
        for (i = 0; i < 6; i++) begin
            random_op(1'b0, '0);
        end
        // one reset edge so only the pipe valid resets can stop the live ops
        rstn = 1'b0;
        tick();
        // anything still queued was wiped by the reset
        exp_rd_q.delete();
        exp_data_q.delete();
        exp_edge_q.delete();
        rstn = 1'b1;
        // scoreboard flags any write here since the queue is empty
        idle(8);
        random_op(1'b1, 5'd7);
        drain();

        $display("TEST OK");
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
rtl/mul_op_pkg.sv
rtl/mul_pipe_pkg.sv
rtl/mul_partial_products.sv
rtl/mul_partial_sum.sv
rtl/mul_issue.sv
rtl/mul_unit.sv
rtl/mul_writeback.sv
rtl/mul_top.sv
verification/mul_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = mul_tb
FILELIST = sources.f
OBJDIR   = obj_dir
LOG      = sim.log
PASS_MSG = TEST OK
FAIL_MSG = TEST FAILED

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

sim: build
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
